//--- src/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // seven 0x55 bytes, then the SFD
    localparam logic [63:0] preamble_sfd = 64'h5555_5555_5555_55d5;

    localparam mac_addr_t broadcast_mac = 48'hffff_ffff_ffff;

    localparam logic [15:0] ethertype_ipv4 = 16'h0800;
    localparam logic [15:0] ethertype_arp  = 16'h0806;
    localparam logic [7:0]  ip_proto_udp   = 8'h11;

    // section sizes in bytes
    localparam logic [7:0] eth_hdr_len = 8'd14;
    localparam logic [7:0] ip_hdr_len  = 8'd20;
    localparam logic [7:0] udp_hdr_len = 8'd8;

    localparam logic [31:0] crc_poly_reflected = 32'hedb8_8320;
    localparam logic [31:0] crc_init           = 32'hffff_ffff;
    localparam logic [31:0] crc_residue        = 32'hdebb_20e3; // register after a good FCS

endpackage

`default_nettype wire

//--- src/eth_rx_ctrl_pkg.sv
`default_nettype none

package eth_rx_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        ETH_HDR,
        IP_HDR,
        UDP_HDR,
        UDP_DATA,
        DRAIN,       // ARP, padding and rejected frames
        DONE
    } parse_state_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_ARP,
        KIND_UDP,
        KIND_OTHER
    } frame_kind_t;

endpackage

`default_nettype wire

//--- src/eth_sfd_detect.sv
`timescale 1ns/100ps
`default_nettype none

module eth_sfd_detect (
    input  wire logic       phy_rx_clk,
    input  wire logic       phy_rx_rst,
    input  wire logic [7:0] phy_rxd,
    input  wire logic       phy_rx_dv,
    output logic            sfd_seen
);
    import eth_frame_pkg::*;

    logic [63:0] shift_q; // last eight valid bytes

    always_ff @(posedge phy_rx_clk) begin
        if (phy_rx_rst) begin
            shift_q <= '0;
        end else if (phy_rx_dv) begin
            shift_q <= {shift_q[55:0], phy_rxd};
        end else begin
            shift_q <= '0; // gap restarts the search
        end
    end

    // high in the cycle that carries the first header byte
    assign sfd_seen = (shift_q == preamble_sfd);

endmodule

`default_nettype wire

//--- src/eth_rx_parser.sv
`timescale 1ns/100ps
`default_nettype none

module eth_rx_parser (
    input  wire logic                   phy_rx_clk,
    input  wire logic                   phy_rx_rst,
    input  wire logic                   phy_rx_dv,
    input  wire logic                   phy_rx_er,
    input  wire logic                   sfd_seen,
    input  wire logic                   mac_ok,
    input  wire logic                   is_ipv4,
    input  wire logic                   is_arp,
    input  wire logic                   ip_dst_ok,
    input  wire logic                   proto_udp,
    input  wire logic                   ip_csum_ok,
    input  wire logic                   fcs_ok,
    input  wire logic [15:0]            udp_payload_len,
    output eth_rx_ctrl_pkg::parse_state_t state,
    output logic [15:0]                 byte_idx,
    output logic                        payload_valid,
    output logic                        payload_last,
    output logic [7:0]                  payload_data,
    input  wire logic [7:0]             phy_rxd,
    output logic                        frame_done,
    output logic                        frame_ok,
    output eth_rx_ctrl_pkg::frame_kind_t frame_kind
);
    import eth_frame_pkg::*;
    import eth_rx_ctrl_pkg::*;

    localparam logic [15:0] eth_last = 16'(eth_hdr_len) - 16'd1;
    localparam logic [15:0] ip_last  = 16'(ip_hdr_len) - 16'd1;
    localparam logic [15:0] udp_last = 16'(udp_hdr_len) - 16'd1;

    logic        err_q;     // sticky per frame
    logic        seen_q;    // whole payload streamed
    frame_kind_t kind_q;
    logic        p1_valid;
    logic        p1_last;
    logic [7:0]  p1_data;
    logic        hdr_open;

    assign hdr_open = (state == ETH_HDR) || (state == IP_HDR) || (state == UDP_HDR);

    always_ff @(posedge phy_rx_clk) begin
        if (phy_rx_rst) begin
            state      <= IDLE;
            byte_idx   <= '0;
            err_q      <= 1'b0;
            seen_q     <= 1'b0;
            kind_q     <= KIND_NONE;
            p1_valid   <= 1'b0;
            p1_last    <= 1'b0;
            frame_done <= 1'b0;
            frame_ok   <= 1'b0;
            frame_kind <= KIND_NONE;
        end else begin
            p1_valid   <= 1'b0;
            p1_last    <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (sfd_seen) begin
                        state    <= ETH_HDR;
                        byte_idx <= 16'd1; // byte 0 goes by in this cycle
                        err_q    <= phy_rx_er;
                        seen_q   <= 1'b0;
                        kind_q   <= KIND_NONE;
                    end
                end
                DONE: state <= IDLE;
                default: begin
                    if (!phy_rx_dv) begin
                        frame_done <= 1'b1;
                        frame_ok   <= !err_q && fcs_ok && !hdr_open &&
                                      (kind_q != KIND_UDP || seen_q);
                        frame_kind <= kind_q;
                        state      <= DONE;
                    end else begin
                        if (phy_rx_er)
                            err_q <= 1'b1;
                        byte_idx <= byte_idx + 16'd1;
                        case (state)
                            ETH_HDR: if (byte_idx == eth_last) begin
                                byte_idx <= '0;
                                kind_q   <= is_arp ? KIND_ARP : KIND_OTHER;
                                if (mac_ok && is_ipv4) begin
                                    state <= IP_HDR;
                                end else begin
                                    state <= DRAIN;
                                    if (!mac_ok || !is_arp)
                                        err_q <= 1'b1;
                                end
                            end
                            IP_HDR: if (byte_idx == ip_last) begin
                                byte_idx <= '0;
                                state    <= UDP_HDR;
                            end
                            UDP_HDR: begin
                                // IP flags settle one cycle after the IP header
                                if (byte_idx == '0) begin
                                    if (proto_udp)
                                        kind_q <= KIND_UDP;
                                    if (!ip_dst_ok || !ip_csum_ok || !proto_udp) begin
                                        err_q <= 1'b1;
                                        state <= DRAIN;
                                    end
                                end
                                if (byte_idx == udp_last) begin
                                    byte_idx <= '0;
                                    if (!proto_udp) begin
                                        err_q <= 1'b1; // short UDP length
                                        state <= DRAIN;
                                    end else if (udp_payload_len == '0) begin
                                        seen_q <= 1'b1;
                                        state  <= DRAIN;
                                    end else begin
                                        state <= UDP_DATA;
                                    end
                                end
                            end
                            UDP_DATA: begin
                                p1_valid <= 1'b1;
                                p1_last  <= (byte_idx == udp_payload_len - 16'd1);
                                if (byte_idx == udp_payload_len - 16'd1) begin
                                    seen_q <= 1'b1;
                                    state  <= DRAIN;
                                end
                            end
                            default: byte_idx <= '0; // drain, fcs keeps running
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        p1_data <= phy_rxd;
    end

    // second payload stage
    always_ff @(posedge phy_rx_clk) begin
        if (phy_rx_rst) begin
            payload_valid <= 1'b0;
            payload_last  <= 1'b0;
        end else begin
            payload_valid <= p1_valid;
            payload_last  <= p1_last;
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        payload_data <= p1_data;
    end

    a_done_single: assert property (@(posedge phy_rx_clk) disable iff (phy_rx_rst)
        frame_done |=> !frame_done);

    a_payload_in_data: assert property (@(posedge phy_rx_clk) disable iff (phy_rx_rst)
        payload_valid |-> $past(state == UDP_DATA, 2));

endmodule

`default_nettype wire

//--- src/eth_field_capture.sv
`timescale 1ns/100ps
`default_nettype none

module eth_field_capture #(
    parameter eth_frame_pkg::mac_addr_t local_mac = 48'h02_00_00_00_00_01,
    parameter eth_frame_pkg::ip_addr_t  local_ip  = 32'hc0a8_0001
) (
    input  wire logic                          phy_rx_clk,
    input  wire logic                          phy_rx_rst,
    input  wire logic [7:0]                    phy_rxd,
    input  wire logic                          phy_rx_dv,
    input  wire eth_rx_ctrl_pkg::parse_state_t state,
    input  wire logic [15:0]                   byte_idx,
    output logic                               mac_ok,
    output logic                               is_ipv4,
    output logic                               is_arp,
    output logic                               ip_dst_ok,
    output logic                               proto_udp,
    output logic [15:0]                        udp_payload_len
);
    import eth_frame_pkg::*;
    import eth_rx_ctrl_pkg::*;

    mac_addr_t   dst_mac;
    ip_addr_t    dst_ip;
    logic [7:0]  type_hi;
    logic [7:0]  ip_proto;
    logic [7:0]  len_hi;
    logic [15:0] udp_len;
    logic        len_short;

    always_ff @(posedge phy_rx_clk) begin
        // idle shifts too, so byte 0 is in place on entry
        if ((state == IDLE && phy_rx_dv) || (state == ETH_HDR && byte_idx < 16'd6))
            dst_mac <= {dst_mac[39:0], phy_rxd};
        if (state == ETH_HDR && byte_idx == 16'd12)
            type_hi <= phy_rxd;
        if (state == IP_HDR && byte_idx == 16'd9)
            ip_proto <= phy_rxd;
        if (state == IP_HDR && byte_idx >= 16'd16)
            dst_ip <= {dst_ip[23:0], phy_rxd};
        if (state == UDP_HDR && byte_idx == 16'd4)
            len_hi <= phy_rxd;
        if (state == UDP_HDR && byte_idx == 16'd5)
            udp_len <= {len_hi, phy_rxd};
    end

    always_ff @(posedge phy_rx_clk) begin
        if (phy_rx_rst || state == IDLE) begin
            len_short <= 1'b0;
        end else if (state == UDP_HDR && byte_idx == 16'd5) begin
            len_short <= ({len_hi, phy_rxd} < 16'(udp_hdr_len));
        end
    end

    assign mac_ok          = (dst_mac == local_mac) || (dst_mac == broadcast_mac);
    assign is_ipv4         = ({type_hi, phy_rxd} == ethertype_ipv4); // used on byte 13
    assign is_arp          = ({type_hi, phy_rxd} == ethertype_arp);
    assign ip_dst_ok       = (dst_ip == local_ip);
    assign proto_udp       = (ip_proto == ip_proto_udp) && !len_short;
    assign udp_payload_len = udp_len - 16'(udp_hdr_len);

    // stored length below the UDP header size never passes as UDP
    a_short_len_rejected: assert property (@(posedge phy_rx_clk) disable iff (phy_rx_rst)
        (state == UDP_HDR && byte_idx > 16'd5 && udp_len < 16'(udp_hdr_len)) |-> !proto_udp);

endmodule

`default_nettype wire

//--- src/ip_hdr_checksum.sv
`timescale 1ns/100ps
`default_nettype none

module ip_hdr_checksum (
    input  wire logic                          phy_rx_clk,
    input  wire logic                          phy_rx_rst,
    input  wire logic [7:0]                    phy_rxd,
    input  wire eth_rx_ctrl_pkg::parse_state_t state,
    input  wire logic [15:0]                   byte_idx,
    output logic                               ip_csum_ok
);
    import eth_frame_pkg::*;
    import eth_rx_ctrl_pkg::*;

    logic [7:0]  hi_byte;  // even byte of the word
    logic [15:0] sum_q;
    logic [16:0] sum_wide;

    assign sum_wide = {1'b0, sum_q} + {1'b0, hi_byte, phy_rxd};

    always_ff @(posedge phy_rx_clk) begin
        if (phy_rx_rst || state == IDLE) begin
            sum_q <= '0;
        end else if (state == IP_HDR && byte_idx < 16'(ip_hdr_len) && byte_idx[0]) begin
            sum_q <= sum_wide[15:0] + {15'd0, sum_wide[16]}; // end-around carry
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        if (state == IP_HDR && !byte_idx[0])
            hi_byte <= phy_rxd;
    end

    // checksum field included, so a good header folds to all ones
    assign ip_csum_ok = (sum_q == 16'hffff);

endmodule

`default_nettype wire

//--- src/eth_fcs_check.sv
`timescale 1ns/100ps
`default_nettype none

module eth_fcs_check (
    input  wire logic                          phy_rx_clk,
    input  wire logic                          phy_rx_rst,
    input  wire logic [7:0]                    phy_rxd,
    input  wire logic                          phy_rx_dv,
    input  wire eth_rx_ctrl_pkg::parse_state_t state,
    output logic                               fcs_ok
);
    import eth_frame_pkg::*;
    import eth_rx_ctrl_pkg::*;

    logic [31:0] crc_q;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] c;
        c = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly_reflected) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge phy_rx_clk) begin
        if (phy_rx_rst) begin
            crc_q <= crc_init;
        end else if (state == IDLE) begin
            // fresh start every idle cycle, the last one is header byte 0
            crc_q <= crc_byte(crc_init, phy_rxd);
        end else if (phy_rx_dv && state != DONE) begin
            crc_q <= crc_byte(crc_q, phy_rxd);
        end
    end

    // frame plus FCS leaves the fixed residue
    assign fcs_ok = (crc_q == crc_residue);

endmodule

`default_nettype wire

//--- src/eth_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module eth_rx_top #(
    parameter eth_frame_pkg::mac_addr_t local_mac = 48'h02_00_00_00_00_01,
    parameter eth_frame_pkg::ip_addr_t  local_ip  = 32'hc0a8_0001
) (
    input  wire logic                   phy_rx_clk,
    input  wire logic                   phy_rx_rst,
    input  wire logic [7:0]             phy_rxd,
    input  wire logic                   phy_rx_dv,
    input  wire logic                   phy_rx_er,
    output logic [7:0]                  payload_data,
    output logic                        payload_valid,
    output logic                        payload_last,
    output logic                        frame_done,
    output logic                        frame_ok,
    output eth_rx_ctrl_pkg::frame_kind_t frame_kind
);
    import eth_rx_ctrl_pkg::*;

    parse_state_t state;
    logic [15:0]  byte_idx;
    logic [15:0]  udp_payload_len;
    logic         sfd_seen;
    logic         mac_ok;
    logic         is_ipv4;
    logic         is_arp;
    logic         ip_dst_ok;
    logic         proto_udp;
    logic         ip_csum_ok;
    logic         fcs_ok;

    eth_sfd_detect sfd_i (
        .phy_rx_clk, .phy_rx_rst, .phy_rxd, .phy_rx_dv, .sfd_seen
    );

    eth_field_capture #(.local_mac(local_mac), .local_ip(local_ip)) capture_i (
        .phy_rx_clk, .phy_rx_rst, .phy_rxd, .phy_rx_dv, .state, .byte_idx,
        .mac_ok, .is_ipv4, .is_arp, .ip_dst_ok, .proto_udp, .udp_payload_len
    );

    ip_hdr_checksum csum_i (
        .phy_rx_clk, .phy_rx_rst, .phy_rxd, .state, .byte_idx, .ip_csum_ok
    );

    eth_fcs_check fcs_i (
        .phy_rx_clk, .phy_rx_rst, .phy_rxd, .phy_rx_dv, .state, .fcs_ok
    );

    eth_rx_parser parser_i (
        .phy_rx_clk, .phy_rx_rst, .phy_rx_dv, .phy_rx_er, .sfd_seen,
        .mac_ok, .is_ipv4, .is_arp, .ip_dst_ok, .proto_udp, .ip_csum_ok, .fcs_ok,
        .udp_payload_len, .state, .byte_idx,
        .payload_valid, .payload_last, .payload_data, .phy_rxd,
        .frame_done, .frame_ok, .frame_kind
    );

endmodule

`default_nettype wire

//--- tb/eth_rx_frames.svh
`ifndef ETH_RX_FRAMES_SVH
`define ETH_RX_FRAMES_SVH

localparam logic [47:0] station_mac = 48'h02_12_34_56_78_9a;
localparam logic [31:0] station_ip  = 32'hc0a8_0a05;

localparam int ft_udp      = 0;
localparam int ft_arp      = 1;
localparam int ft_preamble = 2; // preamble bytes only, no SFD

localparam int c_none     = 0;
localparam int c_bcast    = 1; // broadcast destination, still a good frame
localparam int c_bad_mac  = 2;
localparam int c_bad_ip   = 3;
localparam int c_icmp     = 4;
localparam int c_bad_csum = 5;
localparam int c_bad_fcs  = 6;
localparam int c_rx_er    = 7;

// reflected CRC-32, one data bit at a time from the lsb
function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] d);
    int   b;
    logic fb;
    for (b = 0; b < 8; b++) begin
        fb  = crc[0] ^ d[b];
        crc = crc >> 1;
        if (fb)
            crc = crc ^ 32'hedb8_8320;
    end
    return crc;
endfunction

// checksum field of the IPv4 header that starts at first
function automatic logic [15:0] ip_checksum(ref logic [7:0] b[$], input int first);
    logic [31:0] s;
    int          k;
    s = 0;
    for (k = 0; k < 20; k += 2)
        s = s + {b[first + k], b[first + k + 1]};
    while (s[31:16] != 0)
        s = {16'd0, s[15:0]} + {16'd0, s[31:16]}; // fold the carries back in
    return ~s[15:0];
endfunction

// bytes on the wire, preamble and FCS included
function automatic int frame_bytes(input int ftype, input int plen);
    int body;
    if (ftype == ft_preamble)
        return 8;
    body = (ftype == ft_arp) ? 42 : 42 + plen;
    if (body < 60)
        body = 60; // minimum frame before the FCS
    return 8 + body + 4;
endfunction

task automatic build_frame(input int ftype, input int plen, input int corrupt,
                           ref logic [7:0] frame[$], ref logic [7:0] payload[$],
                           output int er_idx);
    logic [7:0]  body[$];
    logic [47:0] dst;
    logic [31:0] dip;
    logic [31:0] crc;
    logic [15:0] csum;
    int          i;
    frame   = {};
    payload = {};
    er_idx  = -1;
    repeat (7) frame.push_back(8'h55);
    if (ftype == ft_preamble) begin
        frame.push_back(8'h55); // SFD never comes
        return;
    end
    frame.push_back(8'hd5);
    dst = (ftype == ft_arp || corrupt == c_bcast) ? 48'hffff_ffff_ffff : station_mac;
    if (corrupt == c_bad_mac)
        dst = station_mac ^ 48'h1;
    for (i = 5; i >= 0; i--)
        body.push_back(dst[i*8 +: 8]);
    for (i = 0; i < 6; i++)
        body.push_back(8'ha0 + 8'(i)); // source MAC
    if (ftype == ft_arp) begin
        body.push_back(8'h08);
        body.push_back(8'h06);
        for (i = 0; i < 28; i++)
            body.push_back(8'($urandom));
    end else begin
        dip = (corrupt == c_bad_ip) ? station_ip ^ 32'h1 : station_ip;
        body.push_back(8'h08);
        body.push_back(8'h00);
        body.push_back(8'h45);
        body.push_back(8'h00);
        body.push_back(8'((28 + plen) >> 8)); // IP total length
        body.push_back(8'(28 + plen));
        body.push_back(8'h00);
        body.push_back(8'h00);
        body.push_back(8'h40);
        body.push_back(8'h00);
        body.push_back(8'h40);
        body.push_back((corrupt == c_icmp) ? 8'h01 : 8'h11);
        body.push_back(8'h00);
        body.push_back(8'h00);
        for (i = 0; i < 4; i++)
            body.push_back(8'h0a + 8'(i)); // source IP
        for (i = 3; i >= 0; i--)
            body.push_back(dip[i*8 +: 8]);
        csum     = ip_checksum(body, 14);
        body[24] = csum[15:8];
        body[25] = csum[7:0];
        if (corrupt == c_bad_csum)
            body[25] = body[25] ^ 8'hff;
        body.push_back(8'h12);
        body.push_back(8'h34);
        body.push_back(8'h56);
        body.push_back(8'h78);
        body.push_back(8'((8 + plen) >> 8)); // UDP length
        body.push_back(8'(8 + plen));
        body.push_back(8'h00);
        body.push_back(8'h00);
        for (i = 0; i < plen; i++) begin
            payload.push_back(8'($urandom));
            body.push_back(payload[i]);
        end
        if (corrupt == c_rx_er)
            er_idx = 8 + 42 + plen / 2;
    end
    while (body.size() < 60)
        body.push_back(8'h00);
    crc = 32'hffff_ffff;
    foreach (body[j])
        crc = crc32_next(crc, body[j]);
    crc = ~crc;
    for (i = 0; i < 4; i++)
        body.push_back(crc[i*8 +: 8]); // FCS goes out lsb byte first
    if (corrupt == c_bad_fcs)
        body[body.size() - 1] = body[body.size() - 1] ^ 8'hff;
    foreach (body[j])
        frame.push_back(body[j]);
endtask

`endif

//--- tb/eth_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module eth_rx_tb;
    import eth_rx_ctrl_pkg::*;

    `include "eth_rx_frames.svh"

    localparam int clk_period = 20;
    localparam int gap_cycles = 12;
    localparam int done_wait  = 8;  // cycles from dv low until frame_done must show

    typedef struct {
        string       name;
        int          ftype;
        int          plen;       // below zero picks a random length
        int          corrupt;
        logic        exp_ok;
        frame_kind_t exp_kind;
        logic        exp_stream; // payload reaches the output
    } test_row_t;

    logic        phy_rx_clk;
    logic        phy_rx_rst;
    logic [7:0]  phy_rxd;
    logic        phy_rx_dv;
    logic        phy_rx_er;
    logic [7:0]  payload_data;
    logic        payload_valid;
    logic        payload_last;
    logic        frame_done;
    logic        frame_ok;
    frame_kind_t frame_kind;

    test_row_t   tests[$];
    logic [7:0]  got_payload[$];
    int          last_pos[$];   // payload index of each payload_last
    int          done_count;
    logic        got_ok;
    frame_kind_t got_kind;
    int          budget_cycles = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    eth_rx_top #(.local_mac(station_mac), .local_ip(station_ip)) dut_i (
        .phy_rx_clk, .phy_rx_rst, .phy_rxd, .phy_rx_dv, .phy_rx_er,
        .payload_data, .payload_valid, .payload_last,
        .frame_done, .frame_ok, .frame_kind
    );

    initial begin
        phy_rx_clk = 1'b0;
        forever #(clk_period / 2) phy_rx_clk = ~phy_rx_clk;
    end

    // output monitor for the test loop
    always @(posedge phy_rx_clk) begin
        if (!phy_rx_rst) begin
            if (payload_valid) begin
                if (payload_last)
                    last_pos.push_back(got_payload.size());
                got_payload.push_back(payload_data);
            end
            if (frame_done) begin
                done_count = done_count + 1;
                got_ok     = frame_ok;
                got_kind   = frame_kind;
            end
        end
    end

    task automatic run_row(input test_row_t row);
        logic [7:0] frame[$];
        logic [7:0] exp_payload[$];
        int         er_idx;
        int         exp_done;
        int         exp_count;
        int         exp_lasts;
        int         errs;
        int         w;
        errs = 0;
        build_frame(row.ftype, row.plen, row.corrupt, frame, exp_payload, er_idx);
        @(negedge phy_rx_clk);
        got_payload.delete();
        last_pos.delete();
        done_count = 0;
        foreach (frame[i]) begin
            @(posedge phy_rx_clk);
            phy_rxd   <= frame[i];
            phy_rx_dv <= 1'b1;
            phy_rx_er <= (i == er_idx);
        end
        @(posedge phy_rx_clk);
        phy_rxd   <= 8'h00;
        phy_rx_dv <= 1'b0;
        phy_rx_er <= 1'b0;
        exp_done = (row.ftype == ft_preamble) ? 0 : 1;
        w = 0;
        while (exp_done == 1 && done_count == 0 && w < done_wait) begin
            @(negedge phy_rx_clk);
            w++;
        end
        if (exp_done == 1 && done_count == 0) begin
            $display("%s: no frame_done within %0d cycles of the frame end",
                     row.name, done_wait);
            errs++;
        end
        repeat (gap_cycles) @(negedge phy_rx_clk); // stray pulses would land here
        if (done_count != exp_done && done_count != 0) begin
            $display("ERR %s frame_done count: expected %0d, actual %0d",
                     row.name, exp_done, done_count);
            errs++;
        end
        if (exp_done == 1 && done_count == 1) begin
            if (got_ok !== row.exp_ok) begin
                $display("ERR %s frame_ok: expected %0b, actual %0b",
                         row.name, row.exp_ok, got_ok);
                errs++;
            end
            if (got_kind !== row.exp_kind) begin
                $display("ERR %s frame_kind: expected %s, actual %s",
                         row.name, row.exp_kind.name(), got_kind.name());
                errs++;
            end
        end
        exp_count = row.exp_stream ? exp_payload.size() : 0;
        exp_lasts = (exp_count > 0) ? 1 : 0;
        if (got_payload.size() != exp_count) begin
            $display("ERR %s payload bytes: expected %0d, actual %0d",
                     row.name, exp_count, got_payload.size());
            errs++;
        end else begin
            foreach (got_payload[i]) begin
                if (got_payload[i] !== exp_payload[i] && errs == 0) begin
                    $display("ERR %s payload byte %0d: expected %02h, actual %02h",
                             row.name, i, exp_payload[i], got_payload[i]);
                    errs++;
                end
            end
        end
        if (last_pos.size() != exp_lasts) begin
            $display("ERR %s payload_last count: expected %0d, actual %0d",
                     row.name, exp_lasts, last_pos.size());
            errs++;
        end else if (exp_lasts == 1 && last_pos[0] != exp_count - 1) begin
            $display("ERR %s payload_last position: expected %0d, actual %0d",
                     row.name, exp_count - 1, last_pos[0]);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("%s: passed", row.name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", row.name, errs);
        end
    endtask

    initial begin
        int total;
        phy_rx_rst = 1'b1;
        phy_rxd    = 8'h00;
        phy_rx_dv  = 1'b0;
        phy_rx_er  = 1'b0;
        done_count = 0;
        void'($urandom(53));
        tests.push_back('{"udp_local",       ft_udp,      -1, c_none,     1'b1, KIND_UDP,   1'b1});
        tests.push_back('{"udp_broadcast",   ft_udp,      -1, c_bcast,    1'b1, KIND_UDP,   1'b1});
        tests.push_back('{"udp_short_pad",   ft_udp,       5, c_none,     1'b1, KIND_UDP,   1'b1});
        tests.push_back('{"arp_request",     ft_arp,       0, c_none,     1'b1, KIND_ARP,   1'b0});
        tests.push_back('{"wrong_mac",       ft_udp,      -1, c_bad_mac,  1'b0, KIND_OTHER, 1'b0});
        tests.push_back('{"wrong_ip",        ft_udp,      -1, c_bad_ip,   1'b0, KIND_UDP,   1'b0});
        tests.push_back('{"icmp_proto",      ft_udp,      -1, c_icmp,     1'b0, KIND_OTHER, 1'b0});
        tests.push_back('{"bad_ip_checksum", ft_udp,      -1, c_bad_csum, 1'b0, KIND_UDP,   1'b0});
        tests.push_back('{"bad_fcs",         ft_udp,      -1, c_bad_fcs,  1'b0, KIND_UDP,   1'b1});
        tests.push_back('{"rx_er_byte",      ft_udp,      30, c_rx_er,    1'b0, KIND_UDP,   1'b1});
        tests.push_back('{"preamble_only",   ft_preamble,  0, c_none,     1'b0, KIND_NONE,  1'b0});
        tests.push_back('{"udp_after_noise", ft_udp,      -1, c_none,     1'b1, KIND_UDP,   1'b1});
        total = 5 + 2;
        foreach (tests[t]) begin
            if (tests[t].plen < 0)
                tests[t].plen = 1 + int'($urandom % 120);
            total += frame_bytes(tests[t].ftype, tests[t].plen) + 2 + done_wait + gap_cycles;
        end
        budget_cycles = total;
        repeat (5) @(posedge phy_rx_clk);
        phy_rx_rst <= 1'b0;
        @(negedge phy_rx_clk);
        if (payload_valid !== 1'b0 || payload_last !== 1'b0 || frame_done !== 1'b0 ||
            dut_i.state !== IDLE) begin
            $display("reset: outputs not quiet or parser not idle after reset");
            fail_count++;
        end else begin
            pass_count++;
            $display("reset: passed");
        end
        foreach (tests[t])
            run_row(tests[t]);
        $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // limit is twice the bytes on the wire plus all gaps
    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * 2 * clk_period);
        $display("watchdog: run still busy after %0d clock cycles, stopping",
                 budget_cycles * 2);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tb
src/eth_frame_pkg.sv
src/eth_rx_ctrl_pkg.sv
src/eth_sfd_detect.sv
src/eth_rx_parser.sv
src/eth_field_capture.sv
src/ip_hdr_checksum.sv
src/eth_fcs_check.sv
src/eth_rx_top.sv
tb/eth_rx_tb.sv

//--- Bender.yml
package:
  name: eth_rx_check

sources:
  - src/eth_frame_pkg.sv
  - src/eth_rx_ctrl_pkg.sv
  - src/eth_sfd_detect.sv
  - src/eth_rx_parser.sv
  - src/eth_field_capture.sv
  - src/ip_hdr_checksum.sv
  - src/eth_fcs_check.sv
  - src/eth_rx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/eth_rx_tb.sv
